// ==== vlog.f ====
+incdir+.
axi_router_pkg.sv
axi_rr_arbiter.sv
axi_router_rd.sv
axi_router_wr.sv
axi_router.sv
tb_axi_slave.sv
tb_axi_router.sv

// ==== Makefile ====
# Verilator build and run of the AXI router testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_axi_router
FILELIST = vlog.f
LOG      = run.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, check run.log for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_axi_router.sv ====
/* Testbench for the AXI router. Masters drive on the falling edge and
   sample 1 time unit later; each master works in its own half of a page. */

`include "axi_router_macros.svh"

module tb_axi_router import axi_router_pkg::*; ();

    localparam data_t fill_pattern = 32'h5a3c_96e1;
    localparam int    limit        = 400;

    logic clk;
    logic reset;

    logic [`AXI_NUM_IN-1:0]  in_ar_valid, in_ar_ready, in_r_valid, in_r_ready;
    logic [`AXI_NUM_IN-1:0]  in_aw_valid, in_aw_ready, in_w_valid, in_w_ready;
    logic [`AXI_NUM_IN-1:0]  in_b_valid, in_b_ready;
    cmd_t                    in_ar [`AXI_NUM_IN];
    cmd_t                    in_aw [`AXI_NUM_IN];
    r_beat_t                 in_r [`AXI_NUM_IN];
    w_beat_t                 in_w [`AXI_NUM_IN];
    resp_t                   in_b [`AXI_NUM_IN];
    logic [`AXI_NUM_OUT-1:0] out_ar_valid, out_ar_ready, out_r_valid, out_r_ready;
    logic [`AXI_NUM_OUT-1:0] out_aw_valid, out_aw_ready, out_w_valid, out_w_ready;
    logic [`AXI_NUM_OUT-1:0] out_b_valid, out_b_ready, slave_err;
    cmd_t                    out_ar [`AXI_NUM_OUT];
    cmd_t                    out_aw [`AXI_NUM_OUT];
    r_beat_t                 out_r [`AXI_NUM_OUT];
    w_beat_t                 out_w [`AXI_NUM_OUT];
    resp_t                   out_b [`AXI_NUM_OUT];

    // Byte model of all memory
    logic [7:0] model [addr_t];
    int         errors, checks, tests, err_start;
    string      test_name;
    bit         gap;
    logic [1:0] rd_busy, wr_busy;
    addr_t      a0, a1;
    len_t       l;

    axi_router axi_router_i (.*);

    for (genvar s = 0; s < `AXI_NUM_OUT; s++) begin : slaves
        tb_axi_slave #(.slave_id(s), .fill_pattern(fill_pattern)) slave_i (
            .clk(clk), .ar_valid(out_ar_valid[s]), .ar_ready(out_ar_ready[s]),
            .ar(out_ar[s]), .r_valid(out_r_valid[s]), .r_ready(out_r_ready[s]),
            .r(out_r[s]), .aw_valid(out_aw_valid[s]), .aw_ready(out_aw_ready[s]),
            .aw(out_aw[s]), .w_valid(out_w_valid[s]), .w_ready(out_w_ready[s]),
            .w(out_w[s]), .b_valid(out_b_valid[s]), .b_ready(out_b_ready[s]),
            .b(out_b[s]), .err(slave_err[s])
        );
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(string what, logic [63:0] exp, logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic report_timeout(string what, int m);
        errors++;
        $display("Timeout in %s: master %0d waited too long for %s", test_name, m, what);
    endtask

    function automatic data_t model_word(addr_t a);
        data_t w;
        w = a ^ fill_pattern;
        for (int k = 0; k < 4; k++) begin
            if (model.exists(a + addr_t'(k))) w[8*k +: 8] = model[a + addr_t'(k)];
        end
        return w;
    endfunction

    // Bit 11 keeps the masters apart, bit 12 picks the slave
    function automatic addr_t rand_addr(int m);
        return (addr_t'($urandom % 4) << 13) | (addr_t'($urandom % 2) << 12) |
               (addr_t'(m) << 11) | (addr_t'($urandom % 496) << 2);
    endfunction

    task automatic do_read(int m, addr_t addr, len_t len);
        int      n;
        int      beats;
        bit      done;
        r_beat_t got;
        @(negedge clk);
        rd_busy[m]     = 1'b1;
        in_ar[m]       = '{addr, len};
        in_ar_valid[m] = 1'b1;
        n = 0;
        #1;
        while (!in_ar_ready[m] && n < limit) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (n >= limit) report_timeout("read command accept", m);
        beats = 0;
        done  = 1'b0;
        n     = 0;
        while (!done && n < limit) begin
            @(negedge clk);
            in_ar_valid[m] = 1'b0;
            in_r_ready[m]  = gap ? (($urandom % 2) != 0) : 1'b1;
            #1;
            n++;
            if (in_r_valid[m] && in_r_ready[m]) begin
                got = in_r[m];
                check("read data", model_word(addr + addr_t'(4 * beats)), got.data);
                // Slaves answer with the low word-index bits of the beat address
                check("read resp", resp_t'((addr + addr_t'(4 * beats)) >> 2), got.resp);
                check("read last", beats == int'(len), got.last);
                beats++;
                n    = 0;
                done = got.last || beats > int'(len);
            end
        end
        if (!done) report_timeout("read data", m);
        check("read beat count", int'(len) + 1, beats);
        @(negedge clk);
        in_r_ready[m] = 1'b0;
        rd_busy[m]    = 1'b0;
    endtask

    task automatic do_write(int m, addr_t addr, len_t len);
        int    n;
        bit    ok;
        data_t dat [16];
        strb_t stb [16];
        for (int k = 0; k <= int'(len); k++) begin
            dat[k] = $urandom;
            stb[k] = strb_t'($urandom);
        end
        @(negedge clk);
        wr_busy[m]     = 1'b1;
        in_aw[m]       = '{addr, len};
        in_aw_valid[m] = 1'b1;
        n = 0;
        #1;
        while (!in_aw_ready[m] && n < limit) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (n >= limit) report_timeout("write command accept", m);
        for (int k = 0; k <= int'(len); k++) begin
            n  = 0;
            ok = 1'b0;
            while (!ok && n < limit) begin
                @(negedge clk);
                in_aw_valid[m] = 1'b0;
                if (n == 0) in_w_valid[m] = 1'b0;
                if (!in_w_valid[m]) begin
                    in_w[m]       = '{dat[k], stb[k], k == int'(len)};
                    in_w_valid[m] = gap ? (($urandom % 2) != 0) : 1'b1;
                end
                #1;
                n++;
                ok = in_w_valid[m] && in_w_ready[m];
            end
            if (!ok) report_timeout("write data ready", m);
        end
        n  = 0;
        ok = 1'b0;
        while (!ok && n < limit) begin
            @(negedge clk);
            if (n == 0) in_w_valid[m] = 1'b0;
            in_b_ready[m] = gap ? (($urandom % 2) != 0) : 1'b1;
            #1;
            n++;
            if (in_b_valid[m] && in_b_ready[m]) begin
                check("write resp", resp_t'(addr >> 2), in_b[m]);
                ok = 1'b1;
            end
        end
        if (!ok) report_timeout("write response", m);
        for (int k = 0; k <= int'(len); k++) begin
            for (int j = 0; j < 4; j++) begin
                if (stb[k][j]) model[addr + addr_t'(4 * k + j)] = dat[k][8*j +: 8];
            end
        end
        @(negedge clk);
        in_b_ready[m] = 1'b0;
        wr_busy[m]    = 1'b0;
    endtask

    task automatic master_stream(int m, int count);
        repeat (count) begin
            if (($urandom % 2) != 0) do_read(m, rand_addr(m), len_t'($urandom));
            else do_write(m, rand_addr(m), len_t'($urandom));
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic finish_test();
        tests++;
        $display("test %s: %s", test_name, (errors == err_start) ? "ok" : "errors");
    endtask

    // A master must see no read data or response while it has none open
    initial begin
        forever begin
            @(negedge clk);
            #1;
            for (int m = 0; m < `AXI_NUM_IN; m++) begin
                if (!reset && in_r_valid[m] && !rd_busy[m]) begin
                    errors++;
                    $display("Master %0d got read data with no read open", m);
                end
                if (!reset && in_b_valid[m] && !wr_busy[m]) begin
                    errors++;
                    $display("Master %0d got a write response with no write open", m);
                end
            end
        end
    end

    initial begin
        #200000;
        $display("Timeout: the simulation did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(60989));
        errors = 0;
        checks = 0;
        tests  = 0;
        rd_busy = '0;
        wr_busy = '0;
        gap = 1'b0;
        reset = 1'b1;
        in_ar_valid = '0;
        in_aw_valid = '0;
        in_w_valid  = '0;
        in_r_ready  = '0;
        in_b_ready  = '0;
        for (int m = 0; m < `AXI_NUM_IN; m++) begin
            in_ar[m] = '0;
            in_aw[m] = '0;
            in_w[m]  = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;

        start_test("reset_idle");
        check("valids toward masters", 0, {in_r_valid, in_b_valid});
        check("valids toward slaves", 0, {out_ar_valid, out_aw_valid, out_w_valid});
        check("command readies", 0, {in_ar_ready, in_aw_ready});
        finish_test();

        start_test("read_burst");
        for (int i = 0; i < 4; i++) do_read(i % 2, rand_addr(i % 2), len_t'($urandom));
        finish_test();

        start_test("write_read");
        for (int i = 0; i < 4; i++) begin
            a0 = rand_addr(i % 2);
            l  = len_t'($urandom);
            do_write(i % 2, a0, l);
            do_read(i % 2, a0, l);
        end
        finish_test();

        start_test("concurrent_streams");
        fork
            master_stream(0, 12);
            master_stream(1, 12);
        join
        finish_test();

        start_test("ready_gaps");
        gap = 1'b1;
        fork
            master_stream(0, 12);
            master_stream(1, 12);
        join
        finish_test();

        start_test("read_write_parallel");
        a0 = rand_addr(0);
        a1 = rand_addr(1);
        l  = len_t'($urandom);
        fork
            do_read(0, a0, l);
            do_write(1, a1, l);
        join
        do_read(0, a1, l);
        check("slave errors", 0, slave_err);
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_axi_slave.sv ====
/* Behavioral AXI slave for the testbench. One read and one write burst at a
   time; unwritten words read as their address xor fill_pattern. Responses
   carry the low two bits of the word index of the address. */

`include "axi_router_macros.svh"

module tb_axi_slave import axi_router_pkg::*; #(
    parameter int    slave_id     = 0,
    parameter data_t fill_pattern = '0
) (
    input  logic    clk,
    input  logic    ar_valid,
    output logic    ar_ready,
    input  cmd_t    ar,
    output logic    r_valid,
    input  logic    r_ready,
    output r_beat_t r,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  cmd_t    aw,
    input  logic    w_valid,
    output logic    w_ready,
    input  w_beat_t w,
    output logic    b_valid,
    input  logic    b_ready,
    output resp_t   b,
    output logic    err
);

    localparam int limit = 400;

    data_t mem [addr_t];

    function automatic data_t read_word(addr_t a);
        return mem.exists(a) ? mem[a] : (a ^ fill_pattern);
    endfunction

    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        b        = '0;
        err      = 1'b0;
    end

    // Read side
    initial begin
        cmd_t  c;
        addr_t a;
        int    n;
        forever begin
            @(negedge clk);
            r_valid  = 1'b0;
            ar_ready = ($urandom % 2) != 0;
            #1;
            if (ar_valid && ar_ready) begin
                c = ar;
                if (c.addr[`AXI_INTERLEAVE_BIT] != slave_id[0]) begin
                    $display("slave %0d got a read for address %h", slave_id, c.addr);
                    err = 1'b1;
                end
                for (int k = 0; k <= int'(c.len); k++) begin
                    n = 0;
                    do begin
                        @(negedge clk);
                        if (n == 0) begin
                            ar_ready = 1'b0;
                            r_valid  = 1'b0;
                            a = c.addr + addr_t'(4 * k);
                            r = '{read_word(a), resp_t'(a >> 2), k == int'(c.len)};
                        end
                        if (!r_valid) r_valid = ($urandom % 4) != 0;
                        #1;
                        n++;
                    end while (!(r_valid && r_ready) && n < limit);
                    if (n >= limit) begin
                        $display("slave %0d timed out waiting for read ready", slave_id);
                        err = 1'b1;
                    end
                end
            end
        end
    end

    // Write side
    initial begin
        cmd_t  c;
        data_t word;
        addr_t a;
        int    n;
        forever begin
            @(negedge clk);
            b_valid  = 1'b0;
            aw_ready = ($urandom % 2) != 0;
            #1;
            if (aw_valid && aw_ready) begin
                c = aw;
                if (c.addr[`AXI_INTERLEAVE_BIT] != slave_id[0]) begin
                    $display("slave %0d got a write for address %h", slave_id, c.addr);
                    err = 1'b1;
                end
                for (int k = 0; k <= int'(c.len); k++) begin
                    n = 0;
                    do begin
                        @(negedge clk);
                        aw_ready = 1'b0;
                        w_ready  = ($urandom % 2) != 0;
                        #1;
                        n++;
                    end while (!(w_valid && w_ready) && n < limit);
                    if (n >= limit) begin
                        $display("slave %0d timed out waiting for write data", slave_id);
                        err = 1'b1;
                    end
                    a    = c.addr + addr_t'(4 * k);
                    word = read_word(a);
                    for (int j = 0; j < 4; j++) begin
                        if (w.strb[j]) word[8*j +: 8] = w.data[8*j +: 8];
                    end
                    mem[a] = word;
                    if (w.last != (k == int'(c.len))) begin
                        $display("slave %0d saw last on the wrong write beat", slave_id);
                        err = 1'b1;
                    end
                end
                b = resp_t'(c.addr >> 2);
                n = 0;
                do begin
                    @(negedge clk);
                    w_ready = 1'b0;
                    if (!b_valid) b_valid = ($urandom % 4) != 0;
                    #1;
                    n++;
                end while (!(b_valid && b_ready) && n < limit);
                if (n >= limit) begin
                    $display("slave %0d timed out waiting for response ready", slave_id);
                    err = 1'b1;
                end
            end
        end
    end

endmodule

// ==== axi_router.sv ====
/* Two-master, two-slave AXI router. Read and write paths are independent,
   each with one burst in flight. Every address maps to a slave. */

`include "axi_router_macros.svh"

module axi_router import axi_router_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,

    // Master side
    input  logic [`AXI_NUM_IN-1:0]  in_ar_valid,
    output logic [`AXI_NUM_IN-1:0]  in_ar_ready,
    input  cmd_t                    in_ar [`AXI_NUM_IN],
    output logic [`AXI_NUM_IN-1:0]  in_r_valid,
    input  logic [`AXI_NUM_IN-1:0]  in_r_ready,
    output r_beat_t                 in_r [`AXI_NUM_IN],
    input  logic [`AXI_NUM_IN-1:0]  in_aw_valid,
    output logic [`AXI_NUM_IN-1:0]  in_aw_ready,
    input  cmd_t                    in_aw [`AXI_NUM_IN],
    input  logic [`AXI_NUM_IN-1:0]  in_w_valid,
    output logic [`AXI_NUM_IN-1:0]  in_w_ready,
    input  w_beat_t                 in_w [`AXI_NUM_IN],
    output logic [`AXI_NUM_IN-1:0]  in_b_valid,
    input  logic [`AXI_NUM_IN-1:0]  in_b_ready,
    output resp_t                   in_b [`AXI_NUM_IN],

    // Slave side
    output logic [`AXI_NUM_OUT-1:0] out_ar_valid,
    input  logic [`AXI_NUM_OUT-1:0] out_ar_ready,
    output cmd_t                    out_ar [`AXI_NUM_OUT],
    input  logic [`AXI_NUM_OUT-1:0] out_r_valid,
    output logic [`AXI_NUM_OUT-1:0] out_r_ready,
    input  r_beat_t                 out_r [`AXI_NUM_OUT],
    output logic [`AXI_NUM_OUT-1:0] out_aw_valid,
    input  logic [`AXI_NUM_OUT-1:0] out_aw_ready,
    output cmd_t                    out_aw [`AXI_NUM_OUT],
    output logic [`AXI_NUM_OUT-1:0] out_w_valid,
    input  logic [`AXI_NUM_OUT-1:0] out_w_ready,
    output w_beat_t                 out_w [`AXI_NUM_OUT],
    input  logic [`AXI_NUM_OUT-1:0] out_b_valid,
    output logic [`AXI_NUM_OUT-1:0] out_b_ready,
    input  resp_t                   out_b [`AXI_NUM_OUT]
);

    axi_router_rd rd_i (
        .clk          (clk),
        .reset        (reset),
        .in_ar_valid  (in_ar_valid),
        .in_ar_ready  (in_ar_ready),
        .in_ar        (in_ar),
        .in_r_valid   (in_r_valid),
        .in_r_ready   (in_r_ready),
        .in_r         (in_r),
        .out_ar_valid (out_ar_valid),
        .out_ar_ready (out_ar_ready),
        .out_ar       (out_ar),
        .out_r_valid  (out_r_valid),
        .out_r_ready  (out_r_ready),
        .out_r        (out_r)
    );

    axi_router_wr wr_i (
        .clk          (clk),
        .reset        (reset),
        .in_aw_valid  (in_aw_valid),
        .in_aw_ready  (in_aw_ready),
        .in_aw        (in_aw),
        .in_w_valid   (in_w_valid),
        .in_w_ready   (in_w_ready),
        .in_w         (in_w),
        .in_b_valid   (in_b_valid),
        .in_b_ready   (in_b_ready),
        .in_b         (in_b),
        .out_aw_valid (out_aw_valid),
        .out_aw_ready (out_aw_ready),
        .out_aw       (out_aw),
        .out_w_valid  (out_w_valid),
        .out_w_ready  (out_w_ready),
        .out_w        (out_w),
        .out_b_valid  (out_b_valid),
        .out_b_ready  (out_b_ready),
        .out_b        (out_b)
    );

endmodule

// ==== axi_router_wr.sv ====
/* Write path. One burst in flight at a time: command, then the write
   beats of the owning master, then a single response back to it. */

`include "axi_router_macros.svh"

module axi_router_wr import axi_router_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [`AXI_NUM_IN-1:0]  in_aw_valid,
    output logic [`AXI_NUM_IN-1:0]  in_aw_ready,
    input  cmd_t                    in_aw [`AXI_NUM_IN],
    input  logic [`AXI_NUM_IN-1:0]  in_w_valid,
    output logic [`AXI_NUM_IN-1:0]  in_w_ready,
    input  w_beat_t                 in_w [`AXI_NUM_IN],
    output logic [`AXI_NUM_IN-1:0]  in_b_valid,
    input  logic [`AXI_NUM_IN-1:0]  in_b_ready,
    output resp_t                   in_b [`AXI_NUM_IN],

    output logic [`AXI_NUM_OUT-1:0] out_aw_valid,
    input  logic [`AXI_NUM_OUT-1:0] out_aw_ready,
    output cmd_t                    out_aw [`AXI_NUM_OUT],
    output logic [`AXI_NUM_OUT-1:0] out_w_valid,
    input  logic [`AXI_NUM_OUT-1:0] out_w_ready,
    output w_beat_t                 out_w [`AXI_NUM_OUT],
    input  logic [`AXI_NUM_OUT-1:0] out_b_valid,
    output logic [`AXI_NUM_OUT-1:0] out_b_ready,
    input  resp_t                   out_b [`AXI_NUM_OUT]
);

    wr_state_t  state;
    in_sel_t    owner;
    out_sel_t   slave;
    cmd_t       cmd_q;
    in_sel_t    grant;
    logic       grant_valid;
    logic       aw_xfer;
    logic       w_last_xfer;
    logic       b_xfer;

    axi_rr_arbiter arb_i (
        .clk         (clk),
        .reset       (reset),
        .req         (in_aw_valid),
        .busy        (state != wr_idle),
        .accept      (aw_xfer),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    assign aw_xfer     = |(in_aw_valid & in_aw_ready);
    assign w_last_xfer = in_w_valid[owner] && out_w_ready[slave] && in_w[owner].last;
    assign b_xfer      = out_b_valid[slave] && in_b_ready[owner];

    always_comb begin
        in_aw_ready  = '0;
        in_w_ready   = '0;
        in_b_valid   = '0;
        out_aw_valid = '0;
        out_w_valid  = '0;
        out_b_ready  = '0;
        case (state)
            wr_idle: if (grant_valid) in_aw_ready[grant] = 1'b1;
            wr_cmd:  out_aw_valid[slave] = 1'b1;
            wr_data: begin
                out_w_valid[slave] = in_w_valid[owner];
                in_w_ready[owner]  = out_w_ready[slave];
            end
            wr_resp: begin
                in_b_valid[owner]  = out_b_valid[slave];
                out_b_ready[slave] = in_b_ready[owner];
            end
            default: ;
        endcase
        for (int i = 0; i < `AXI_NUM_IN; i++) begin
            in_b[i] = out_b[slave];
        end
        for (int j = 0; j < `AXI_NUM_OUT; j++) begin
            out_aw[j] = cmd_q;
            out_w[j]  = in_w[owner];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= wr_idle;
            owner <= '0;
            slave <= '0;
        end else begin
            case (state)
                wr_idle: if (aw_xfer) begin
                    owner <= grant;
                    slave <= out_sel_t'(in_aw[grant].addr[`AXI_INTERLEAVE_BIT]);
                    state <= wr_cmd;
                end
                wr_cmd:  if (out_aw_ready[slave]) state <= wr_data;
                wr_data: if (w_last_xfer) state <= wr_resp;
                wr_resp: if (b_xfer) state <= wr_idle;
                default: state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_xfer) cmd_q <= in_aw[grant];
    end

    // Beats go only to the slave decoded from the accepted command
    assert property (@(posedge clk) disable iff (reset)
        (|out_w_valid) |-> (out_w_valid == (`AXI_NUM_OUT'(1) << cmd_q.addr[`AXI_INTERLEAVE_BIT])));

endmodule

// ==== axi_router_rd.sv ====
/* Read path. One burst in flight at a time; the slave is chosen by the
   interleave bit of the address. Read beats pass through combinationally. */

`include "axi_router_macros.svh"

module axi_router_rd import axi_router_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [`AXI_NUM_IN-1:0]  in_ar_valid,
    output logic [`AXI_NUM_IN-1:0]  in_ar_ready,
    input  cmd_t                    in_ar [`AXI_NUM_IN],
    output logic [`AXI_NUM_IN-1:0]  in_r_valid,
    input  logic [`AXI_NUM_IN-1:0]  in_r_ready,
    output r_beat_t                 in_r [`AXI_NUM_IN],

    output logic [`AXI_NUM_OUT-1:0] out_ar_valid,
    input  logic [`AXI_NUM_OUT-1:0] out_ar_ready,
    output cmd_t                    out_ar [`AXI_NUM_OUT],
    input  logic [`AXI_NUM_OUT-1:0] out_r_valid,
    output logic [`AXI_NUM_OUT-1:0] out_r_ready,
    input  r_beat_t                 out_r [`AXI_NUM_OUT]
);

    rd_state_t  state;
    in_sel_t    owner;
    out_sel_t   slave;
    cmd_t       cmd_q;
    in_sel_t    grant;
    logic       grant_valid;
    logic       ar_xfer;

    axi_rr_arbiter arb_i (
        .clk         (clk),
        .reset       (reset),
        .req         (in_ar_valid),
        .busy        (state != rd_idle),
        .accept      (ar_xfer),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    assign ar_xfer = |(in_ar_valid & in_ar_ready);

    always_comb begin
        in_ar_ready  = '0;
        in_r_valid   = '0;
        out_ar_valid = '0;
        out_r_ready  = '0;
        if (state == rd_idle && grant_valid) begin
            in_ar_ready[grant] = 1'b1;
        end
        if (state == rd_cmd) begin
            out_ar_valid[slave] = 1'b1;
        end
        if (state == rd_data) begin
            in_r_valid[owner]  = out_r_valid[slave];
            out_r_ready[slave] = in_r_ready[owner];
        end
        for (int i = 0; i < `AXI_NUM_IN; i++) begin
            in_r[i] = out_r[slave];
        end
        for (int j = 0; j < `AXI_NUM_OUT; j++) begin
            out_ar[j] = cmd_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rd_idle;
            owner <= '0;
            slave <= '0;
        end else begin
            case (state)
                rd_idle: if (ar_xfer) begin
                    owner <= grant;
                    slave <= out_sel_t'(in_ar[grant].addr[`AXI_INTERLEAVE_BIT]);
                    state <= rd_cmd;
                end
                rd_cmd: if (out_ar_ready[slave]) state <= rd_data;
                rd_data: if (out_r_valid[slave] && in_r_ready[owner] && out_r[slave].last) begin
                    state <= rd_idle;
                end
                default: state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_xfer) cmd_q <= in_ar[grant];
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(in_r_valid));

endmodule

// ==== axi_rr_arbiter.sv ====
/* Round-robin arbiter for one path. Priority rotates only on accept;
   the grant is frozen and grant_valid low while busy is high. */

`include "axi_router_macros.svh"

module axi_rr_arbiter import axi_router_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  req_vec_t    req,
    input  logic        busy,
    input  logic        accept,
    output in_sel_t     grant,
    output logic        grant_valid
);

    in_sel_t    last;
    in_sel_t    pick;
    logic       found;
    int         idx;

    // First requester after the last winner
    always_comb begin
        pick  = last;
        found = 1'b0;
        idx   = 0;
        for (int k = 1; k <= `AXI_NUM_IN; k++) begin
            idx = (int'(last) + k) % `AXI_NUM_IN;
            if (!found && req[idx]) begin
                pick  = in_sel_t'(idx);
                found = 1'b1;
            end
        end
    end

    assign grant       = busy ? last : pick;
    assign grant_valid = !busy && found;

    always_ff @(posedge clk) begin
        if (reset) begin
            last <= in_sel_t'(`AXI_NUM_IN - 1);
        end else if (accept) begin
            last <= grant;
        end
    end

    assert property (@(posedge clk) disable iff (reset) grant_valid |-> req[grant]);
    assert property (@(posedge clk) disable iff (reset) accept |-> grant_valid);

endmodule

// ==== axi_router_pkg.sv ====
/* Shared types of the router. Widths come from the macros header,
   which must be compiled first. */

`include "axi_router_macros.svh"

package axi_router_pkg;

    typedef logic [`AXI_ADDR_W-1:0]         addr_t;
    typedef logic [`AXI_DATA_W-1:0]         data_t;
    typedef logic [`AXI_DATA_W/8-1:0]       strb_t;
    typedef logic [`AXI_LEN_W-1:0]          len_t;
    typedef logic [1:0]                     resp_t;
    typedef logic [$clog2(`AXI_NUM_IN)-1:0] in_sel_t;
    typedef logic [$clog2(`AXI_NUM_OUT)-1:0] out_sel_t;
    typedef logic [`AXI_NUM_IN-1:0]         req_vec_t;

    // Read and write commands share one layout
    typedef struct packed {
        addr_t  addr;
        len_t   len;
    } cmd_t;

    typedef struct packed {
        data_t  data;
        resp_t  resp;
        logic   last;
    } r_beat_t;

    typedef struct packed {
        data_t  data;
        strb_t  strb;
        logic   last;
    } w_beat_t;

    typedef enum logic [1:0] {
        rd_idle,
        rd_cmd,
        rd_data
    } rd_state_t;

    typedef enum logic [1:0] {
        wr_idle,
        wr_cmd,
        wr_data,
        wr_resp
    } wr_state_t;

endpackage

// ==== axi_router_macros.svh ====
/* Widths and port counts of the router. Two masters and two slaves only;
   the interleave bit picks the slave on 4 KB boundaries. */

`ifndef AXI_ROUTER_MACROS_SVH
`define AXI_ROUTER_MACROS_SVH

// Bus widths
`define AXI_ADDR_W          32
`define AXI_DATA_W          32
`define AXI_LEN_W           4

// Port counts
`define AXI_NUM_IN          2
`define AXI_NUM_OUT         2

// Address bit that selects the slave
`define AXI_INTERLEAVE_BIT  12

`endif
